//--- hw/host_mux_pkg.sv
// ----------------------------------------
// Host mux shared definitions
// Stream widths and the command and beat
// records used across the receive path
// ----------------------------------------

package host_mux_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------

  // Host stream data width
  localparam int DATA_BITS = 64;

  // One keep bit per data byte
  localparam int KEEP_BITS = DATA_BITS / 8;

  // Region number for up to 16 regions
  localparam int VFID_BITS = 4;

  // Beat count of one run
  localparam int BLEN_BITS = 8;

  // ----------------------------------------
  // Routing command
  // ----------------------------------------

  // One command describes one run of beats
  // len holds the beat count minus one
  // last marks a run that closes a packet
  typedef struct packed {
    logic [VFID_BITS-1:0] vfid;
    logic [BLEN_BITS-1:0] len;
    logic                 last;
  } mux_cmd_t;

  // ----------------------------------------
  // Stream beat
  // ----------------------------------------

  // Data, byte enables and packet end
  // Same layout on the host side and on
  // every region port
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic [KEEP_BITS-1:0] keep;
    logic                 last;
  } axis_beat_t;

  // Record widths for reference
  localparam int CMD_BITS  = $bits(mux_cmd_t);
  localparam int BEAT_BITS = $bits(axis_beat_t);

endpackage

//--- hw/mux_cmd_queue.sv
// ----------------------------------------
// Routing command queue
// Circular buffer holding commands ahead
// of their data, oldest at the output
// ----------------------------------------

`timescale 1ns/1ps

module mux_cmd_queue #(
  // Power of two, at least 2
  parameter int CMD_DEPTH = 4
) (
  input  logic                   aclk,
  input  logic                   aresetn,

  // Command input
  input  logic                   in_valid,
  output logic                   in_ready,
  input  host_mux_pkg::mux_cmd_t in_cmd,

  // Command head towards the router
  output logic                   out_valid,
  input  logic                   out_ready,
  output host_mux_pkg::mux_cmd_t out_cmd
);

  import host_mux_pkg::*;

  localparam int PTR_W = $clog2(CMD_DEPTH);
  localparam int CNT_W = $clog2(CMD_DEPTH + 1);

  // ----------------------------------------
  // Storage and pointers
  // ----------------------------------------

  // Command slots
  mux_cmd_t mem [CMD_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  // Status from occupancy
  assign full  = (count == CNT_W'(CMD_DEPTH));
  assign empty = (count == '0);

  // Full queue still takes a write when the head leaves
  assign in_ready  = !full || out_ready;
  assign out_valid = !empty;
  assign out_cmd   = mem[rd_ptr];

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  // ----------------------------------------
  // Write side
  // ----------------------------------------

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_cmd;
    end
  end

  // ----------------------------------------
  // Pointer and count update
  // ----------------------------------------

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on their own width
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave count alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hw/host_beat_fifo.sv
// ----------------------------------------
// Host beat FIFO
// Buffers host stream beats with keep and
// last, decoupling host bursts from slow
// region ports
// ----------------------------------------

`timescale 1ns/1ps

module host_beat_fifo #(
  // Power of two, at least 2
  parameter int BEAT_DEPTH = 8
) (
  input  logic                     aclk,
  input  logic                     aresetn,

  // Host side
  input  logic                     in_valid,
  output logic                     in_ready,
  input  host_mux_pkg::axis_beat_t in_beat,

  // Beat head towards the router
  output logic                     out_valid,
  input  logic                     out_ready,
  output host_mux_pkg::axis_beat_t out_beat
);

  import host_mux_pkg::*;

  localparam int PTR_W = $clog2(BEAT_DEPTH);
  localparam int CNT_W = $clog2(BEAT_DEPTH + 1);

  // ----------------------------------------
  // Storage and pointers
  // ----------------------------------------

  // Beat slots
  axis_beat_t mem [BEAT_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Entries held
  logic [CNT_W-1:0] count;

  logic full;
  logic empty;
  logic push;
  logic pop;

  assign full  = (count == CNT_W'(BEAT_DEPTH));
  assign empty = (count == '0);

  // Ready also when full if the head drains this cycle
  assign in_ready = !full || out_ready;

  // Head of FIFO, read straight from the array
  assign out_valid = !empty;
  assign out_beat  = mem[rd_ptr];

  // Handshakes on both sides
  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // ----------------------------------------
  // Beat storage
  // ----------------------------------------

  // Written entry shows at the head next cycle
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_beat;
    end
  end

  // ----------------------------------------
  // Control state
  // ----------------------------------------

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Occupancy
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hw/host_stream_router.sv
// ----------------------------------------
// Host stream router
// Command-driven demultiplexer from one
// beat stream to N region streams
// Runs for unknown regions are discarded
// ----------------------------------------

`timescale 1ns/1ps

module host_stream_router #(
  // Region ports, 1 to 16
  parameter int N_ID = 4
) (
  input  logic                                aclk,
  input  logic                                aresetn,

  // Command head
  input  logic                                cmd_valid,
  output logic                                cmd_ready,
  input  host_mux_pkg::mux_cmd_t              cmd,

  // Beat head
  input  logic                                beat_valid,
  output logic                                beat_ready,
  input  host_mux_pkg::axis_beat_t            beat,

  // Region ports
  output logic [N_ID-1:0]                     m_axis_valid,
  input  logic [N_ID-1:0]                     m_axis_ready,
  output host_mux_pkg::axis_beat_t [N_ID-1:0] m_axis
);

  import host_mux_pkg::*;

  // ----------------------------------------
  // State
  // ----------------------------------------

  typedef enum logic {
    ST_IDLE,
    ST_ROUTE
  } state_t;

  state_t state_q;
  state_t state_d;

  // Current run
  logic [VFID_BITS-1:0] vfid_q;
  logic [VFID_BITS-1:0] vfid_d;
  logic [BLEN_BITS-1:0] cnt_q;
  logic [BLEN_BITS-1:0] cnt_d;
  logic                 last_q;
  logic                 last_d;

  // Run targets an existing port
  logic hit;
  // Ready of the selected port
  logic port_ready;
  logic beat_xfer;
  // Final beat of the run transfers
  logic run_done;
  logic take_cmd;

  // ----------------------------------------
  // Beat steering
  // ----------------------------------------

  assign hit = (state_q == ST_ROUTE) && (int'(vfid_q) < N_ID);

  // Pick the ready of the selected region
  always_comb begin
    port_ready = 1'b0;
    for (int i = 0; i < N_ID; i++) begin
      if (int'(vfid_q) == i) begin
        port_ready = m_axis_ready[i];
      end
    end
  end

  // Payload fans out to every port
  // only the selected one sees valid
  always_comb begin
    for (int i = 0; i < N_ID; i++) begin
      m_axis[i].data  = beat.data;
      m_axis[i].keep  = beat.keep;
      // Packet end only when the run closes one
      m_axis[i].last  = beat.last & last_q;
      m_axis_valid[i] = hit && (int'(vfid_q) == i) && beat_valid;
    end
  end

  // Discard runs sink beats at full rate
  always_comb begin
    if (state_q != ST_ROUTE) begin
      beat_ready = 1'b0;
    end else if (hit) begin
      beat_ready = port_ready;
    end else begin
      beat_ready = 1'b1;
    end
  end

  assign beat_xfer = beat_valid && beat_ready;
  assign run_done  = (state_q == ST_ROUTE) && beat_xfer && (cnt_q == '0);

  // ----------------------------------------
  // Command intake
  // ----------------------------------------

  // Next command taken when idle or on the
  // closing beat, so runs follow without a gap
  assign cmd_ready = (state_q == ST_IDLE) || run_done;
  assign take_cmd  = cmd_valid && cmd_ready;

  // ----------------------------------------
  // Next state and run registers
  // ----------------------------------------

  always_comb begin
    state_d = state_q;
    vfid_d  = vfid_q;
    cnt_d   = cnt_q;
    last_d  = last_q;

    if (take_cmd) begin
      // Load a fresh run
      state_d = ST_ROUTE;
      vfid_d  = cmd.vfid;
      cnt_d   = cmd.len;
      last_d  = cmd.last;
    end else if (run_done) begin
      // No command waiting
      state_d = ST_IDLE;
    end else if ((state_q == ST_ROUTE) && beat_xfer) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
      vfid_q  <= '0;
      cnt_q   <= '0;
      last_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      vfid_q  <= vfid_d;
      cnt_q   <= cnt_d;
      last_q  <= last_d;
    end
  end

endmodule

//--- hw/host_mux_src_top.sv
// ----------------------------------------
// Host mux source top level
// Command queue and beat FIFO feeding the
// stream router towards the region ports
// ----------------------------------------

`timescale 1ns/1ps

module host_mux_src_top #(
  parameter int N_ID       = 4,
  parameter int CMD_DEPTH  = 4,
  parameter int BEAT_DEPTH = 8
) (
  input  logic                                aclk,
  input  logic                                aresetn,

  // Routing commands
  input  logic                                s_cmd_valid,
  output logic                                s_cmd_ready,
  input  host_mux_pkg::mux_cmd_t              s_cmd,

  // Host stream
  input  logic                                s_axis_valid,
  output logic                                s_axis_ready,
  input  host_mux_pkg::axis_beat_t            s_axis,

  // Region streams
  output logic [N_ID-1:0]                     m_axis_valid,
  input  logic [N_ID-1:0]                     m_axis_ready,
  output host_mux_pkg::axis_beat_t [N_ID-1:0] m_axis
);

  import host_mux_pkg::*;

  // ----------------------------------------
  // Heads towards the router
  // ----------------------------------------

  logic       cmd_valid;
  logic       cmd_ready;
  mux_cmd_t   cmd;

  logic       beat_valid;
  logic       beat_ready;
  axis_beat_t beat;

  // Command path
  mux_cmd_queue #(
    .CMD_DEPTH (CMD_DEPTH)
  ) u_cmd_queue (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (s_cmd_valid),
    .in_ready  (s_cmd_ready),
    .in_cmd    (s_cmd),
    .out_valid (cmd_valid),
    .out_ready (cmd_ready),
    .out_cmd   (cmd)
  );

  // Data path
  host_beat_fifo #(
    .BEAT_DEPTH (BEAT_DEPTH)
  ) u_beat_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (s_axis_valid),
    .in_ready  (s_axis_ready),
    .in_beat   (s_axis),
    .out_valid (beat_valid),
    .out_ready (beat_ready),
    .out_beat  (beat)
  );

  // Joins both heads and steers each run
  host_stream_router #(
    .N_ID (N_ID)
  ) u_router (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd          (cmd),
    .beat_valid   (beat_valid),
    .beat_ready   (beat_ready),
    .beat         (beat),
    .m_axis_valid (m_axis_valid),
    .m_axis_ready (m_axis_ready),
    .m_axis       (m_axis)
  );

endmodule

//--- sim/host_mux_src_sva.sv
// ----------------------------------------
// Host mux stream protocol checks
// Bound to the top level to check valid
// hold, payload stability, one-hot region
// valid and quiet outputs around reset
// ----------------------------------------

`timescale 1ns/1ps

module host_mux_src_sva #(
  parameter int N_ID = 4
) (
  input logic                                aclk,
  input logic                                aresetn,
  input logic                                s_cmd_valid,
  input logic                                s_cmd_ready,
  input host_mux_pkg::mux_cmd_t              s_cmd,
  input logic                                s_axis_valid,
  input logic                                s_axis_ready,
  input host_mux_pkg::axis_beat_t            s_axis,
  input logic [N_ID-1:0]                     m_axis_valid,
  input logic [N_ID-1:0]                     m_axis_ready,
  input host_mux_pkg::axis_beat_t [N_ID-1:0] m_axis
);

  // Assertion failures seen so far
  int unsigned fail_count = 0;

  // ----------------------------------------
  // Input side hold
  // ----------------------------------------

  a_cmd_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_cmd_valid && !s_cmd_ready |=> s_cmd_valid && $stable(s_cmd))
    else begin
      $error("command valid or payload changed before ready");
      fail_count++;
    end

  a_beat_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axis_valid && !s_axis_ready |=> s_axis_valid && $stable(s_axis))
    else begin
      $error("host beat valid or payload changed before ready");
      fail_count++;
    end

  // ----------------------------------------
  // Region ports
  // ----------------------------------------

  // Stalled beat stays on its port
  for (genvar i = 0; i < N_ID; i++) begin : g_port
    a_port_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      m_axis_valid[i] && !m_axis_ready[i] |=> m_axis_valid[i] && $stable(m_axis[i]))
      else begin
        $error("region %0d dropped valid or changed payload before ready", i);
        fail_count++;
      end
  end

  // One run active at a time
  a_one_hot: assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(m_axis_valid))
    else begin
      $error("more than one region valid in the same cycle");
      fail_count++;
    end

  // Empty buffers and idle router out of reset
  a_reset_quiet: assert property (@(posedge aclk)
    !aresetn |=> (m_axis_valid == '0) && s_cmd_ready && s_axis_ready)
    else begin
      $error("outputs not quiet during or right after reset");
      fail_count++;
    end

endmodule

bind host_mux_src_top host_mux_src_sva #(
  .N_ID (N_ID)
) u_sva (
  .aclk         (aclk),
  .aresetn      (aresetn),
  .s_cmd_valid  (s_cmd_valid),
  .s_cmd_ready  (s_cmd_ready),
  .s_cmd        (s_cmd),
  .s_axis_valid (s_axis_valid),
  .s_axis_ready (s_axis_ready),
  .s_axis       (s_axis),
  .m_axis_valid (m_axis_valid),
  .m_axis_ready (m_axis_ready),
  .m_axis       (m_axis)
);

//--- sim/host_mux_src_tb.sv
// ----------------------------------------
// Host mux source testbench
// Random commands and host beats, random
// region back-pressure, per-region model
// queues checked on every output transfer
// ----------------------------------------

`timescale 1ns/1ps

module host_mux_src_tb;

  import host_mux_pkg::*;

  localparam int N_ID    = 4;
  localparam int N_CMD   = 40;
  // Worst case of 16 beats per run at 4 cycles per beat plus slack
  localparam int TIMEOUT = N_CMD * 16 * 4 + 200;

  logic                  aclk;
  logic                  aresetn;
  logic                  s_cmd_valid;
  logic                  s_cmd_ready;
  mux_cmd_t              s_cmd;
  logic                  s_axis_valid;
  logic                  s_axis_ready;
  axis_beat_t            s_axis;
  logic [N_ID-1:0]       m_axis_valid;
  logic [N_ID-1:0]       m_axis_ready;
  axis_beat_t [N_ID-1:0] m_axis;

  // ----------------------------------------
  // Stimulus and model state
  // ----------------------------------------

  mux_cmd_t   cmd_list [N_CMD];
  axis_beat_t beat_list [$];
  // Accepted at the inputs and not yet paired
  mux_cmd_t   in_cmds [$];
  axis_beat_t in_beats [$];
  // Expected beats per region
  axis_beat_t exp_q [N_ID][$];

  int          run_pos;
  int          exp_total;
  int          out_count;
  int          cmds_acc;
  int          beats_acc;
  int          cycles;
  // Transfer flags from the last sample point
  bit          cmd_acc;
  bit          beat_acc;

  host_mux_src_top #(
    .N_ID (N_ID)
  ) UUT (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .s_cmd_valid  (s_cmd_valid),
    .s_cmd_ready  (s_cmd_ready),
    .s_cmd        (s_cmd),
    .s_axis_valid (s_axis_valid),
    .s_axis_ready (s_axis_ready),
    .s_axis       (s_axis),
    .m_axis_valid (m_axis_valid),
    .m_axis_ready (m_axis_ready),
    .m_axis       (m_axis)
  );

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // ----------------------------------------
  // Failure reporting
  // ----------------------------------------

  task automatic stop_on_failure();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped after the first failure");
  endtask

  task automatic report_mismatch(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    stop_on_failure();
  endtask

  // Bound protocol checker failures
  task automatic check_protocol();
    if (UUT.u_sva.fail_count != 0) begin
      $display("a protocol assertion on the top level ports failed");
      stop_on_failure();
    end
  endtask

  // ----------------------------------------
  // Stimulus generation
  // ----------------------------------------

  // Regions 0 to 4 where region 4 is out of range and discarded
  task automatic build_stimulus();
    mux_cmd_t   c;
    axis_beat_t b;
    for (int k = 0; k < N_CMD; k++) begin
      c.vfid = VFID_BITS'($urandom_range(4, 0));
      c.len  = BLEN_BITS'($urandom_range(15, 0));
      c.last = 1'($urandom_range(1, 0));
      cmd_list[k] = c;
      for (int j = 0; j <= int'(c.len); j++) begin
        b.data = {$urandom, $urandom};
        b.keep = KEEP_BITS'($urandom);
        // Input last forced high on the closing beat
        b.last = (j == int'(c.len)) ? 1'b1 : 1'($urandom_range(1, 0));
        beat_list.push_back(b);
        if (int'(c.vfid) < N_ID) begin
          exp_total++;
        end
      end
    end
  endtask

  task automatic send_cmds();
    for (int k = 0; k < N_CMD; k++) begin
      s_cmd       = cmd_list[k];
      s_cmd_valid = 1'b1;
      do @(negedge aclk); while (!cmd_acc);
    end
    s_cmd_valid = 1'b0;
  endtask

  task automatic send_beats();
    for (int k = 0; k < beat_list.size(); k++) begin
      s_axis       = beat_list[k];
      s_axis_valid = 1'b1;
      do @(negedge aclk); while (!beat_acc);
    end
    s_axis_valid = 1'b0;
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Pair accepted beats with accepted commands in order
  task automatic model_assign();
    mux_cmd_t   cur;
    axis_beat_t b;
    while (in_cmds.size() > 0 && in_beats.size() > 0) begin
      cur = in_cmds[0];
      b   = in_beats.pop_front();
      if (int'(cur.vfid) < N_ID) begin
        // Packet end only when the run closes one
        b.last = b.last & cur.last;
        exp_q[cur.vfid].push_back(b);
      end
      if (run_pos == int'(cur.len)) begin
        void'(in_cmds.pop_front());
        run_pos = 0;
      end else begin
        run_pos++;
      end
    end
  endtask

  task automatic check_outputs();
    axis_beat_t exp;
    for (int i = 0; i < N_ID; i++) begin
      if (m_axis_valid[i] && m_axis_ready[i]) begin
        assert (exp_q[i].size() > 0)
          else report_mismatch($sformatf("unexpected beat on region %0d", i));
        exp = exp_q[i].pop_front();
        assert (m_axis[i] === exp)
          else report_mismatch($sformatf("region %0d got %h, expected %h",
                                         i, m_axis[i], exp));
        out_count++;
      end
    end
  endtask

  function automatic bit drained();
    bit empty;
    empty = (in_cmds.size() == 0) && (in_beats.size() == 0);
    for (int i = 0; i < N_ID; i++) begin
      empty = empty && (exp_q[i].size() == 0);
    end
    return empty;
  endfunction

  // Sample 1 ns before each rising edge
  initial begin
    forever begin
      @(negedge aclk);
      #9;
      cmd_acc  = s_cmd_valid && s_cmd_ready;
      beat_acc = s_axis_valid && s_axis_ready;
      check_protocol();
      if (aresetn) begin
        if (cmd_acc) begin
          in_cmds.push_back(s_cmd);
          cmds_acc++;
        end
        if (beat_acc) begin
          in_beats.push_back(s_axis);
          beats_acc++;
        end
        model_assign();
        check_outputs();
      end
    end
  end

  // Region back-pressure with ready in about 70% of cycles
  initial begin
    forever begin
      @(negedge aclk);
      for (int i = 0; i < N_ID; i++) begin
        m_axis_ready[i] = ($urandom_range(99, 0) < 70);
      end
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge aclk);
      cycles++;
      if (cycles >= TIMEOUT) begin
        $display("run did not finish within %0d cycles", TIMEOUT);
        stop_on_failure();
      end
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    aresetn      = 1'b0;
    s_cmd_valid  = 1'b0;
    s_cmd        = '0;
    s_axis_valid = 1'b0;
    s_axis       = '0;
    m_axis_ready = '0;
    void'($urandom(32'h236f5aa8));
    build_stimulus();
    repeat (4) @(negedge aclk);
    aresetn = 1'b1;
    // Command and data streams run independently
    fork
      send_cmds();
      send_beats();
    join
    while (!drained()) @(negedge aclk);
    check_protocol();
    if (cmds_acc == N_CMD && beats_acc == beat_list.size() && out_count == exp_total) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      report_mismatch($sformatf("counts differ, cmds %0d beats %0d out %0d of %0d",
                                cmds_acc, beats_acc, out_count, exp_total));
    end
  end

endmodule

//--- files.f
hw/host_mux_pkg.sv
hw/mux_cmd_queue.sv
hw/host_beat_fifo.sv
hw/host_stream_router.sv
hw/host_mux_src_top.sv
sim/host_mux_src_sva.sv
sim/host_mux_src_tb.sv
